// File: logic/display_timing.sv
// 800x525 raster counter for 640x480 at 60 Hz
// gives coordinates, syncs, data enable and a frame start pulse

`timescale 1ns/1ps

module display_timing (
    input  logic                   clk_pix,
    input  logic                   arst_n,
    output starfield_pkg::raster_t raster
);
    import starfield_pkg::*;

    cord_t sx;  // current column
    cord_t sy;  // current line
    logic  line_end;
    logic  frame_end;

    assign line_end  = (sx == cord_t'(H_TOTAL - 1));
    assign frame_end = (sy == cord_t'(V_TOTAL - 1));

    // horizontal counter, wraps at 799
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
        end else if (line_end) begin
            sx <= '0;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // vertical counter steps on the line wrap
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sy <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end
    end

    // decode straight from the counters, same cycle as sx/sy
    always_comb begin
        raster.sx = sx;
        raster.sy = sy;

        // hsync low for 656..751
        raster.hsync = !((sx >= cord_t'(H_ACTIVE + H_FP)) &&
                         (sx <  cord_t'(H_ACTIVE + H_FP + H_SYNC)));

        // vsync low on lines 490 and 491
        raster.vsync = !((sy >= cord_t'(V_ACTIVE + V_FP)) &&
                         (sy <  cord_t'(V_ACTIVE + V_FP + V_SYNC)));

        raster.de = (sx < cord_t'(H_ACTIVE)) && (sy < cord_t'(V_ACTIVE));

        raster.frame_start = (sx == '0) && (sy == '0);  // one cycle per frame
    end

endmodule

// File: logic/lfsr_stars.sv
// starfield source: 17-bit galois lfsr stepped once per visible area pixel
// reloads the seed each frame so the pattern repeats; decides lit and brightness

`timescale 1ns/1ps

module lfsr_stars (
    input  logic                     clk_pix,
    input  logic                     arst_n,
    input  starfield_pkg::raster_t   raster,
    input  starfield_pkg::star_cfg_t cfg,
    output starfield_pkg::star_t     star
);
    import starfield_pkg::*;

    lfsr_t sreg;       // lfsr state
    lfsr_t sreg_next;  // one galois step ahead
    logic  in_area;
    logic  dens_hit;   // top density bits all one
    logic  step;

    assign in_area = (raster.sx < cfg.area_w) && (raster.sy < cfg.area_h);
    assign step    = raster.de && in_area;

    // shift right, feed output bit into the tapped positions
    assign sreg_next = {1'b0, sreg[LFSR_W-1:1]} ^ (sreg[0] ? LFSR_TAPS : '0);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sreg <= DEFAULT_SEED;
        end else if (raster.frame_start) begin
            // seed from the active set before this edge's copy
            sreg <= cfg.seed;
        end else if (step) begin
            sreg <= sreg_next;
        end
    end

    // density n means bits 16 down to 17-n must all be set
    always_comb begin
        dens_hit = 1'b1;  // density 0 lights every pixel
        for (int i = 0; i < DENS_MAX; i++) begin
            if (dens_t'(i) < cfg.density) begin
                dens_hit = dens_hit & sreg[LFSR_W-1-i];
            end
        end
    end

    always_comb begin
        star.lit    = step && dens_hit;
        star.bright = sreg[3:0];  // low bits as intensity
    end

endmodule

// File: logic/pixel_mixer.sv
// output stage: applies enable and tint to the star result
// registers colour and syncs together, one cycle behind the raster

`timescale 1ns/1ps

module pixel_mixer (
    input  logic                     clk_pix,
    input  logic                     arst_n,
    input  starfield_pkg::raster_t   raster,
    input  starfield_pkg::star_t     star,
    input  starfield_pkg::star_cfg_t cfg,
    output logic                     vga_hsync,
    output logic                     vga_vsync,
    output starfield_pkg::chan_t     vga_r,
    output starfield_pkg::chan_t     vga_g,
    output starfield_pkg::chan_t     vga_b
);
    import starfield_pkg::*;

    logic  on;     // star shown this pixel
    chan_t r_nxt;
    chan_t g_nxt;
    chan_t b_nxt;

    // lit already carries de and the area test
    assign on = star.lit && cfg.enable;

    always_comb begin
        r_nxt = (on && cfg.tint[TINT_R]) ? star.bright : '0;
        g_nxt = (on && cfg.tint[TINT_G]) ? star.bright : '0;
        b_nxt = (on && cfg.tint[TINT_B]) ? star.bright : '0;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vga_hsync <= 1'b1;  // inactive
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= raster.hsync;
            vga_vsync <= raster.vsync;
            vga_r     <= r_nxt;
            vga_g     <= g_nxt;
            vga_b     <= b_nxt;
        end
    end

endmodule

// File: logic/star_regs.sv
// axi4-lite register slave for the starfield settings, runs on clk_pix
// bus sees the pending set; display gets the active set copied at frame start

`timescale 1ns/1ps

module star_regs (
    input  logic                                  clk_pix,
    input  logic                                  arst_n,
    // write address and data
    input  logic [starfield_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
    input  logic                                  s_axi_awvalid,
    output logic                                  s_axi_awready,
    input  logic [starfield_pkg::AXI_DATA_W-1:0]  s_axi_wdata,
    input  logic                                  s_axi_wvalid,
    output logic                                  s_axi_wready,
    // write response
    output logic [1:0]                            s_axi_bresp,
    output logic                                  s_axi_bvalid,
    input  logic                                  s_axi_bready,
    // read address and data
    input  logic [starfield_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
    input  logic                                  s_axi_arvalid,
    output logic                                  s_axi_arready,
    output logic [starfield_pkg::AXI_DATA_W-1:0]  s_axi_rdata,
    output logic [1:0]                            s_axi_rresp,
    output logic                                  s_axi_rvalid,
    input  logic                                  s_axi_rready,
    // display side
    input  logic                                  frame_start,
    output starfield_pkg::star_cfg_t              cfg
);
    import starfield_pkg::*;

    star_cfg_t             pend;     // bus-visible settings
    logic                  wr_fire;
    logic                  wr_hit;   // awaddr is mapped
    logic                  rd_fire;
    logic                  rd_hit;   // araddr is mapped
    logic [AXI_DATA_W-1:0] rd_word;
    dens_t                 dens_in;

    // aw and w ready rise together so one check covers both
    assign wr_fire = s_axi_awvalid && s_axi_awready && s_axi_wvalid && s_axi_wready;
    assign rd_fire = s_axi_arvalid && s_axi_arready;

    assign wr_hit = (s_axi_awaddr == REG_CTRL) || (s_axi_awaddr == REG_DENSITY) ||
                    (s_axi_awaddr == REG_AREA) || (s_axi_awaddr == REG_SEED);

    // clamp density to 8
    assign dens_in = (s_axi_wdata[3:0] > dens_t'(DENS_MAX)) ? dens_t'(DENS_MAX)
                                                             : s_axi_wdata[3:0];

    // write channel
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_bresp   <= RESP_OKAY;
        end else begin
            s_axi_awready <= 1'b0;  // ready is a single-cycle pulse
            s_axi_wready  <= 1'b0;
            if (wr_fire) begin
                s_axi_bvalid <= 1'b1;
                s_axi_bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
            end else if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end else if (s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready) begin
                s_axi_awready <= 1'b1;
                s_axi_wready  <= 1'b1;
            end
        end
    end

    // pending set, whole-register writes only
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pend <= CFG_DEFAULT;
        end else if (wr_fire) begin
            case (s_axi_awaddr)
                REG_CTRL: begin
                    pend.enable <= s_axi_wdata[0];
                    pend.tint   <= s_axi_wdata[3:1];
                end
                REG_DENSITY: pend.density <= dens_in;
                REG_AREA: begin
                    pend.area_w <= s_axi_wdata[9:0];
                    pend.area_h <= s_axi_wdata[25:16];
                end
                REG_SEED: begin
                    // zero would lock the lfsr
                    if (s_axi_wdata[LFSR_W-1:0] != '0) begin
                        pend.seed <= s_axi_wdata[LFSR_W-1:0];
                    end
                end
                default: ;  // unmapped, dropped
            endcase
        end
    end

    // read decode from the pending set
    always_comb begin
        rd_word = '0;
        rd_hit  = 1'b1;
        case (s_axi_araddr)
            REG_CTRL:    rd_word[3:0]         = {pend.tint, pend.enable};
            REG_DENSITY: rd_word[3:0]         = pend.density;
            REG_AREA:    rd_word              = {6'b0, pend.area_h, 6'b0, pend.area_w};
            REG_SEED:    rd_word[LFSR_W-1:0]  = pend.seed;
            default:     rd_hit               = 1'b0;  // reads 0
        endcase
    end

    // read channel, arready only while no response pending
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rresp   <= RESP_OKAY;
        end else if (rd_fire) begin
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b1;
            s_axi_rresp   <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end else if (s_axi_rvalid && s_axi_rready) begin
            s_axi_rvalid  <= 1'b0;
            s_axi_arready <= 1'b1;
        end else if (!s_axi_rvalid) begin
            s_axi_arready <= 1'b1;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rd_fire) begin
            s_axi_rdata <= rd_word;
        end
    end

    // active set changes only between frames
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= CFG_DEFAULT;
        end else if (frame_start) begin
            cfg <= pend;
        end
    end

endmodule

// File: logic/starfield_pkg.sv
// shared constants, register map and struct types for the starfield generator
// import into each module body that needs them

package starfield_pkg;

    // 640x480 at 60 Hz, both syncs active low
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BP     = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 800
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 525

    localparam int CORD_W = 10;
    localparam int LFSR_W = 17;
    localparam int DENS_MAX = 8;  // max top bits that must be set

    typedef logic [CORD_W-1:0] cord_t;
    typedef logic [LFSR_W-1:0] lfsr_t;
    typedef logic [3:0]        chan_t;
    typedef logic [3:0]        dens_t;

    localparam lfsr_t LFSR_TAPS    = 17'h12000;  // bits 16 and 13
    localparam lfsr_t DEFAULT_SEED = 17'h1FFFF;

    // axi4-lite bus shape and register map
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL    = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_DENSITY = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_AREA    = 4'h8;
    localparam logic [AXI_ADDR_W-1:0] REG_SEED    = 4'hC;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // tint bit positions, tint is {r, g, b}
    localparam int TINT_R = 2;
    localparam int TINT_G = 1;
    localparam int TINT_B = 0;

    typedef struct packed {
        cord_t sx;
        cord_t sy;
        logic  hsync;        // active low
        logic  vsync;        // active low
        logic  de;
        logic  frame_start;  // first pixel of frame
    } raster_t;

    typedef struct packed {
        logic       enable;
        logic [2:0] tint;
        dens_t      density;
        cord_t      area_w;
        cord_t      area_h;
        lfsr_t      seed;
    } star_cfg_t;

    typedef struct packed {
        logic  lit;
        chan_t bright;
    } star_t;

    localparam star_cfg_t CFG_DEFAULT = '{
        enable:  1'b1,
        tint:    3'b111,
        density: dens_t'(DENS_MAX),
        area_w:  cord_t'(512),
        area_h:  cord_t'(256),
        seed:    DEFAULT_SEED
    };

endpackage

// File: logic/starfield_top.sv
// starfield generator top, 640x480 vga out with axi4-lite settings port
// clk_pix is supplied from outside, bus shares the pixel clock

`timescale 1ns/1ps

module starfield_top (
    input  logic                                  clk_pix,
    input  logic                                  arst_n,
    // axi4-lite slave
    input  logic [starfield_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
    input  logic                                  s_axi_awvalid,
    output logic                                  s_axi_awready,
    input  logic [starfield_pkg::AXI_DATA_W-1:0]  s_axi_wdata,
    input  logic                                  s_axi_wvalid,
    output logic                                  s_axi_wready,
    output logic [1:0]                            s_axi_bresp,
    output logic                                  s_axi_bvalid,
    input  logic                                  s_axi_bready,
    input  logic [starfield_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
    input  logic                                  s_axi_arvalid,
    output logic                                  s_axi_arready,
    output logic [starfield_pkg::AXI_DATA_W-1:0]  s_axi_rdata,
    output logic [1:0]                            s_axi_rresp,
    output logic                                  s_axi_rvalid,
    input  logic                                  s_axi_rready,
    // vga pins
    output logic                                  vga_hsync,
    output logic                                  vga_vsync,
    output starfield_pkg::chan_t                  vga_r,
    output starfield_pkg::chan_t                  vga_g,
    output starfield_pkg::chan_t                  vga_b
);
    import starfield_pkg::*;

    raster_t   raster;  // position, syncs, de
    star_cfg_t cfg;     // active settings
    star_t     star;    // per-pixel star result

    display_timing u_timing (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .raster  (raster)
    );

    lfsr_stars u_stars (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .raster  (raster),
        .cfg     (cfg),
        .star    (star)
    );

    star_regs u_regs (
        .clk_pix       (clk_pix),
        .arst_n        (arst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .frame_start   (raster.frame_start),  // settings swap point
        .cfg           (cfg)
    );

    pixel_mixer u_mixer (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .raster    (raster),
        .star      (star),
        .cfg       (cfg),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the starfield testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module starfield_tb -o starfield_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/starfield_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

// File: sim/star_patterns.txt
# code ctrl density area seed | expected ctrl density area seed | frames, all hex
# area is height<<16 | width; address 0x2 is probed as unmapped in every test
04 f 8 01000200 1ffff  f 8 01000200 1ffff 2
03 5 c 00f00140 0      5 8 00f00140 1ffff 1
03 e 3 03ff03ff 0abcd  e 3 03ff03ff 0abcd 0
05 9 4 006400c8 0ace1  9 4 006400c8 0ace1 3
06 8 8 01000200 1ffff  8 8 01000200 1ffff 2

// File: sim/starfield_tb.sv
// testbench for starfield_top: pattern file drives register tests and frame counts
// a cycle model of raster, lfsr and settings predicts every vga pin

`timescale 1ns/1ps

module starfield_tb;
    import starfield_pkg::*;

    logic clk_pix, arst_n;
    logic [3:0] awaddr, araddr;
    logic [31:0] wdata;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic awready, wready, bvalid, arready, rvalid;
    logic [1:0] bresp, rresp;
    logic [31:0] rdata;
    logic hs, vs;
    chan_t r, g, b;

    int errs = 0, cycles = 0, limit = 32'h7fffffff;
    int n_pass = 0, n_fail = 0;
    logic [31:0] rng = 32'd55;
    logic chk_on = 1'b0;
    logic [31:0] pat_q[$];

    // model state
    int m_sx, m_sy;
    lfsr_t m_lfsr;
    star_cfg_t m_cfg, m_pend;
    logic e_hs, e_vs;
    chan_t e_r, e_g, e_b;

    starfield_top dut (
        .clk_pix(clk_pix), .arst_n(arst_n),
        .s_axi_awaddr(awaddr), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
        .s_axi_wdata(wdata), .s_axi_wvalid(wvalid), .s_axi_wready(wready),
        .s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
        .s_axi_araddr(araddr), .s_axi_arvalid(arvalid), .s_axi_arready(arready),
        .s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rvalid(rvalid),
        .s_axi_rready(rready),
        .vga_hsync(hs), .vga_vsync(vs), .vga_r(r), .vga_g(g), .vga_b(b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;  // 125 MHz sim clock, 8 ns
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errs++;
            $display("ERR %s exp %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic stall();
        int n;
        rng = xorshift(rng);
        n = int'(rng[1:0]);  // 0..3 cycles of back-pressure
        repeat (n) @(negedge clk_pix);
    endtask

    task automatic axi_write(input logic [3:0] a, input logic [31:0] d, input logic [1:0] exp_resp);
        awaddr = a;
        wdata = d;
        awvalid = 1'b1;
        wvalid = 1'b1;
        while (!awready) @(negedge clk_pix);
        check_value("s_axi_wready", 32'h1, 32'(wready));  // rises with awready
        @(negedge clk_pix);  // both channels took it on the last edge
        awvalid = 1'b0;
        wvalid = 1'b0;
        stall();
        bready = 1'b1;
        while (!bvalid) @(negedge clk_pix);
        check_value("bresp", 32'(exp_resp), 32'(bresp));
        @(negedge clk_pix);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] a, input logic [31:0] exp, input logic [1:0] exp_resp);
        araddr = a;
        arvalid = 1'b1;
        while (!arready) @(negedge clk_pix);
        @(negedge clk_pix);
        arvalid = 1'b0;
        stall();
        rready = 1'b1;
        while (!rvalid) @(negedge clk_pix);
        check_value("rdata", exp, rdata);
        check_value("rresp", 32'(exp_resp), 32'(rresp));
        @(negedge clk_pix);
        rready = 1'b0;
    endtask

    // wait for n frame starts of the model raster
    task automatic wait_frames(input int n);
        repeat (n) begin
            @(negedge clk_pix);
            while (!(m_sx == 0 && m_sy == 0)) @(negedge clk_pix);
        end
    endtask

    function automatic logic sync_pin(input logic vert);
        return vert ? vs : hs;
    endfunction

    task automatic measure_sync(input logic vert, output int low_w, output int period);
        low_w = 0;
        period = 0;
        while (sync_pin(vert) == 1'b0) @(negedge clk_pix);
        while (sync_pin(vert) == 1'b1) @(negedge clk_pix);  // now just fell
        while (sync_pin(vert) == 1'b0) begin
            @(negedge clk_pix);
            low_w++;
            period++;
        end
        while (sync_pin(vert) == 1'b1) begin
            @(negedge clk_pix);
            period++;
        end
    endtask

    task automatic check_reset_pins();
        check_value("vga_r", 32'h0, 32'(r));
        check_value("vga_g", 32'h0, 32'(g));
        check_value("vga_b", 32'h0, 32'(b));
        check_value("vga_hsync", 32'h1, 32'(hs));
        check_value("vga_vsync", 32'h1, 32'(vs));
        check_value("s_axi_awready", 32'h0, 32'(awready));
        check_value("s_axi_wready", 32'h0, 32'(wready));
        check_value("s_axi_bvalid", 32'h0, 32'(bvalid));
        check_value("s_axi_arready", 32'h0, 32'(arready));
        check_value("s_axi_rvalid", 32'h0, 32'(rvalid));
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errs == errs_before) begin
            n_pass++;
            $display("test %s ok", name);
        end else begin
            n_fail++;
            $display("test %s failed with %0d errors", name, errs - errs_before);
        end
    endtask

    // reference model, one step per pixel clock
    always @(posedge clk_pix or negedge arst_n) begin
        logic de, area, hit, fs;
        if (!arst_n) begin
            m_sx = 0;
            m_sy = 0;
            m_lfsr = 17'h1FFFF;
            m_pend = '{1'b1, 3'b111, 4'd8, 10'd512, 10'd256, 17'h1FFFF};
            m_cfg = m_pend;
            e_hs = 1'b1;
            e_vs = 1'b1;
            e_r = '0;
            e_g = '0;
            e_b = '0;
        end else begin
            de = (m_sx < H_ACTIVE) && (m_sy < V_ACTIVE);
            area = (m_sx < int'(m_cfg.area_w)) && (m_sy < int'(m_cfg.area_h));
            hit = 1'b1;
            for (int i = 0; i < int'(m_cfg.density); i++) hit = hit & m_lfsr[16-i];
            hit = hit && de && area && m_cfg.enable;
            e_hs = !(m_sx >= H_ACTIVE + H_FP && m_sx < H_ACTIVE + H_FP + H_SYNC);
            e_vs = !(m_sy >= V_ACTIVE + V_FP && m_sy < V_ACTIVE + V_FP + V_SYNC);
            e_r = (hit && m_cfg.tint[2]) ? m_lfsr[3:0] : 4'h0;
            e_g = (hit && m_cfg.tint[1]) ? m_lfsr[3:0] : 4'h0;
            e_b = (hit && m_cfg.tint[0]) ? m_lfsr[3:0] : 4'h0;
            fs = (m_sx == 0) && (m_sy == 0);
            if (fs) m_lfsr = m_cfg.seed;  // seed of the frame that is ending
            else if (de && area) m_lfsr = (m_lfsr >> 1) ^ (m_lfsr[0] ? 17'h12000 : 17'h0);
            if (fs) m_cfg = m_pend;
            if (awvalid && awready && wvalid && wready) begin  // snoop the write handshake
                case (awaddr)
                    4'h0: begin
                        m_pend.enable = wdata[0];
                        m_pend.tint = wdata[3:1];
                    end
                    4'h4: m_pend.density = (wdata[3:0] > 4'd8) ? 4'd8 : wdata[3:0];
                    4'h8: begin
                        m_pend.area_w = wdata[9:0];
                        m_pend.area_h = wdata[25:16];
                    end
                    4'hC: if (wdata[16:0] != 17'h0) m_pend.seed = wdata[16:0];
                    default: ;
                endcase
            end
            m_sx = (m_sx == H_TOTAL - 1) ? 0 : m_sx + 1;
            if (m_sx == 0) m_sy = (m_sy == V_TOTAL - 1) ? 0 : m_sy + 1;
        end
    end

    // pins compared every pixel, mid-cycle
    always @(negedge clk_pix) begin
        if (chk_on) begin
            check_value("vga_hsync", 32'(e_hs), 32'(hs));
            check_value("vga_vsync", 32'(e_vs), 32'(vs));
            check_value("vga_r", 32'(e_r), 32'(r));
            check_value("vga_g", 32'(e_g), 32'(g));
            check_value("vga_b", 32'(e_b), 32'(b));
        end
    end

    always @(posedge clk_pix) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int fd, cnt, e0, frames, w, p;
        string line;
        logic [31:0] v[10];
        {awaddr, araddr, wdata, awvalid, wvalid, bready, arvalid, rready} = '0;
        arst_n = 1'b0;
        frames = 0;
        fd = $fopen("sim/star_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file sim/star_patterns.txt");
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                if (cnt == 10) begin  // comment and blank lines skipped
                    for (int i = 0; i < 10; i++) pat_q.push_back(v[i]);
                    frames += int'(v[9]);
                end
            end
            $fclose(fd);
            limit = (frames + 3) * 420000 + 10000;  // raster test needs up to 3 frames

            e0 = errs;
            repeat (8) begin
                @(negedge clk_pix);
                check_reset_pins();
            end
            arst_n = 1'b1;
            check_reset_pins();
            chk_on = 1'b1;
            end_test("reset", e0);

            e0 = errs;
            measure_sync(1'b0, w, p);
            check_value("hsync_low", 32'(H_SYNC), 32'(w));
            check_value("hsync_period", 32'(H_TOTAL), 32'(p));
            measure_sync(1'b1, w, p);
            check_value("vsync_low", 32'(V_SYNC * H_TOTAL), 32'(w));
            check_value("vsync_period", 32'(V_TOTAL * H_TOTAL), 32'(p));
            end_test("raster", e0);

            for (int t = 0; t < pat_q.size() / 10; t++) begin
                for (int i = 0; i < 10; i++) v[i] = pat_q[t*10 + i];
                e0 = errs;
                axi_write(REG_CTRL, v[1], RESP_OKAY);
                axi_write(REG_DENSITY, v[2], RESP_OKAY);
                axi_write(REG_AREA, v[3], RESP_OKAY);
                axi_write(REG_SEED, v[4], RESP_OKAY);
                axi_write(4'h2, 32'hFFFF_FFFF, RESP_SLVERR);
                axi_read(REG_CTRL, v[5], RESP_OKAY);
                axi_read(REG_DENSITY, v[6], RESP_OKAY);
                axi_read(REG_AREA, v[7], RESP_OKAY);
                axi_read(REG_SEED, v[8], RESP_OKAY);
                axi_read(4'h2, 32'h0, RESP_SLVERR);
                wait_frames(int'(v[9]));
                end_test($sformatf("%02h", v[0][7:0]), e0);
            end

            $display("tests passed %0d, failed %0d, check errors %0d", n_pass, n_fail, errs);
            if (n_fail == 0 && errs == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// File: sources.f
logic/starfield_pkg.sv
logic/display_timing.sv
logic/lfsr_stars.sv
logic/star_regs.sv
logic/pixel_mixer.sv
logic/starfield_top.sv
sim/starfield_tb.sv
